//--- common/mem_arb_pkg.sv
package mem_arb_pkg;

    // Bus and line geometry
    localparam int ADDR_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;
    localparam int LINE_OFFSET_W  = $clog2(LINE_W / 8);
    localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

    // Outstanding read table
    localparam int TABLE_DEPTH    = 16;
    localparam int TABLE_IDX_W    = $clog2(TABLE_DEPTH);

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [BEAT_W-1:0]      beat_t;
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [BEAT_CNT_W-1:0]  beat_cnt_t;
    typedef logic [TABLE_IDX_W-1:0] table_idx_t;

    // Line request from a cache
    typedef struct packed {
        addr_t addr;
        logic  write;
        line_t wdata;
    } line_req_t;

    // Line response payload toward a cache
    typedef struct packed {
        line_t rdata;
    } line_resp_t;

    // One command beat to the banked memory
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        beat_t wdata;
    } bmem_cmd_t;

    // One returning read beat
    typedef struct packed {
        addr_t raddr;
        beat_t rdata;
    } bmem_ret_t;

    // Record of one read in flight
    typedef struct packed {
        logic  valid;
        logic  for_data;
        addr_t addr;
    } table_entry_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_WRITE
    } arb_state_e;

endpackage

//--- hw/burst_assembler.sv
`timescale 1ns/10ps

module burst_assembler (
    input  logic                      clk,
    input  logic                      rst,

    // Returning read beats
    input  mem_arb_pkg::bmem_ret_t    bmem_ret,
    input  logic                      bmem_rvalid,

    // Table lookup and release
    input  mem_arb_pkg::table_entry_t entries [mem_arb_pkg::TABLE_DEPTH],
    output logic                      free,
    output mem_arb_pkg::table_idx_t   free_index,

    // Write-back completion from the arbiter
    input  logic                      wr_done,

    // Line responses
    output mem_arb_pkg::line_resp_t   imem_resp,
    output logic                      imem_resp_valid,
    output mem_arb_pkg::line_resp_t   dmem_resp,
    output logic                      dmem_resp_valid
);

    import mem_arb_pkg::*;

    beat_cnt_t beat_cnt;

    // Beats 0 to 2 of the current burst, beat 0 ends up in the low bits
    logic [(BEATS_PER_LINE-1)*BEAT_W-1:0] beat_buf;

    logic       last_beat;
    logic       hit;
    logic       hit_for_data;
    table_idx_t hit_idx;
    line_t      full_line;
    line_resp_t resp_q;

    assign last_beat = bmem_rvalid && (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));
    assign full_line = {bmem_ret.rdata, beat_buf};

    // At most one valid entry holds a given line
    always_comb begin
        hit          = 1'b0;
        hit_for_data = 1'b0;
        hit_idx      = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (entries[i].valid && entries[i].addr[ADDR_W-1:LINE_OFFSET_W]
                                    == bmem_ret.raddr[ADDR_W-1:LINE_OFFSET_W]) begin
                hit          = 1'b1;
                hit_for_data = entries[i].for_data;
                hit_idx      = table_idx_t'(i);
            end
        end
    end

    assign free       = last_beat && hit;
    assign free_index = hit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt        <= '0;
            imem_resp_valid <= 1'b0;
            dmem_resp_valid <= 1'b0;
        end else begin
            if (bmem_rvalid) begin
                // Counter wraps to zero after the fourth beat
                beat_cnt <= beat_cnt + beat_cnt_t'(1);
            end
            imem_resp_valid <= last_beat && hit && !hit_for_data;
            dmem_resp_valid <= (last_beat && hit && hit_for_data) || wr_done;
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_rvalid && !last_beat) begin
            beat_buf <= {bmem_ret.rdata, beat_buf[(BEATS_PER_LINE-1)*BEAT_W-1:BEAT_W]};
        end
        if (last_beat) begin
            resp_q.rdata <= full_line;
        end
    end

    // One line register serves both caches, the valids pick the receiver
    assign imem_resp = resp_q;
    assign dmem_resp = resp_q;

endmodule

//--- hw/line_req_arbiter.sv
`timescale 1ns/10ps

module line_req_arbiter (
    input  logic                   clk,
    input  logic                   rst,

    // Instruction cache request
    input  mem_arb_pkg::line_req_t imem_req,
    input  logic                   imem_valid,
    output logic                   imem_ready,

    // Data cache request
    input  mem_arb_pkg::line_req_t dmem_req,
    input  logic                   dmem_valid,
    output logic                   dmem_ready,

    // Memory command port
    output mem_arb_pkg::bmem_cmd_t bmem_cmd,
    input  logic                   bmem_ready,

    // Outstanding table interface
    input  logic                   table_full,
    input  logic                   addr_busy,
    output logic                   alloc,
    output mem_arb_pkg::addr_t     alloc_addr,
    output logic                   alloc_for_data,

    // Write-back completion toward the assembler
    output logic                   wr_done
);

    import mem_arb_pkg::*;

    arb_state_e state;
    beat_cnt_t  beat_cnt;

    // Write-back payload, beats 1 to 3 with the next beat in the low bits
    addr_t                    wb_addr;
    logic [LINE_W-BEAT_W-1:0] wb_upper;

    line_req_t sel_req;
    logic      offer_data;
    logic      any_valid;
    logic      grant;
    logic      last_wb_beat;

    // Data side is offered whenever it asks
    assign offer_data = dmem_valid;
    assign any_valid  = dmem_valid || imem_valid;
    assign sel_req    = offer_data ? dmem_req : imem_req;

    // The table checks the offered address for a read already in flight
    assign alloc_addr     = sel_req.addr;
    assign alloc_for_data = offer_data;

    // Writes bypass the table, reads need a free entry and an idle line
    always_comb begin
        grant = 1'b0;
        if (state == ARB_IDLE && bmem_ready && any_valid) begin
            grant = sel_req.write || (!table_full && !addr_busy);
        end
    end

    assign dmem_ready = grant && offer_data;
    assign imem_ready = grant && !offer_data;
    assign alloc      = grant && !sel_req.write;

    assign last_wb_beat = (state == ARB_WRITE) && bmem_ready
                          && (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));

    // Completion pulse in the cycle the last beat is accepted
    assign wr_done = last_wb_beat;

    always_comb begin
        if (state == ARB_WRITE) begin
            bmem_cmd.addr  = wb_addr;
            bmem_cmd.read  = 1'b0;
            bmem_cmd.write = 1'b1;
            bmem_cmd.wdata = wb_upper[BEAT_W-1:0];
        end else begin
            // Beat 0 of a write-back leaves in the grant cycle
            bmem_cmd.addr  = sel_req.addr;
            bmem_cmd.read  = grant && !sel_req.write;
            bmem_cmd.write = grant && sel_req.write;
            bmem_cmd.wdata = sel_req.wdata[BEAT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ARB_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant && sel_req.write) begin
                        state    <= ARB_WRITE;
                        beat_cnt <= beat_cnt_t'(1);
                    end
                end
                ARB_WRITE: begin
                    if (last_wb_beat) begin
                        state    <= ARB_IDLE;
                        beat_cnt <= '0;
                    end else if (bmem_ready) begin
                        beat_cnt <= beat_cnt + beat_cnt_t'(1);
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && grant && sel_req.write) begin
            wb_addr  <= sel_req.addr;
            wb_upper <= sel_req.wdata[LINE_W-1:BEAT_W];
        end else if (state == ARB_WRITE && bmem_ready) begin
            // Next beat moves down once the current one is taken
            wb_upper <= wb_upper >> BEAT_W;
        end
    end

endmodule

//--- hw/mem_arb_top.sv
`timescale 1ns/10ps

module mem_arb_top (
    input  logic                    clk,
    input  logic                    rst,

    // Instruction cache
    input  mem_arb_pkg::line_req_t  imem_req,
    input  logic                    imem_valid,
    output logic                    imem_ready,
    output mem_arb_pkg::line_resp_t imem_resp,
    output logic                    imem_resp_valid,

    // Data cache
    input  mem_arb_pkg::line_req_t  dmem_req,
    input  logic                    dmem_valid,
    output logic                    dmem_ready,
    output mem_arb_pkg::line_resp_t dmem_resp,
    output logic                    dmem_resp_valid,

    // Banked memory
    output mem_arb_pkg::bmem_cmd_t  bmem_cmd,
    input  logic                    bmem_ready,
    input  mem_arb_pkg::bmem_ret_t  bmem_ret,
    input  logic                    bmem_rvalid
);

    import mem_arb_pkg::*;

    logic         table_full;
    logic         addr_busy;
    logic         alloc;
    addr_t        alloc_addr;
    logic         alloc_for_data;
    logic         wr_done;
    logic         free;
    table_idx_t   free_index;
    table_entry_t entries [TABLE_DEPTH];

    line_req_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .imem_req       (imem_req),
        .imem_valid     (imem_valid),
        .imem_ready     (imem_ready),
        .dmem_req       (dmem_req),
        .dmem_valid     (dmem_valid),
        .dmem_ready     (dmem_ready),
        .bmem_cmd       (bmem_cmd),
        .bmem_ready     (bmem_ready),
        .table_full     (table_full),
        .addr_busy      (addr_busy),
        .alloc          (alloc),
        .alloc_addr     (alloc_addr),
        .alloc_for_data (alloc_for_data),
        .wr_done        (wr_done)
    );

    // The offered address doubles as the busy query
    outstanding_table u_table (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .alloc_addr     (alloc_addr),
        .alloc_for_data (alloc_for_data),
        .query_addr     (alloc_addr),
        .full           (table_full),
        .addr_busy      (addr_busy),
        .entries        (entries),
        .free           (free),
        .free_index     (free_index)
    );

    burst_assembler u_assembler (
        .clk             (clk),
        .rst             (rst),
        .bmem_ret        (bmem_ret),
        .bmem_rvalid     (bmem_rvalid),
        .entries         (entries),
        .free            (free),
        .free_index      (free_index),
        .wr_done         (wr_done),
        .imem_resp       (imem_resp),
        .imem_resp_valid (imem_resp_valid),
        .dmem_resp       (dmem_resp),
        .dmem_resp_valid (dmem_resp_valid)
    );

endmodule

//--- hw/outstanding_table.sv
`timescale 1ns/10ps

module outstanding_table (
    input  logic                      clk,
    input  logic                      rst,

    // Allocation from the arbiter
    input  logic                      alloc,
    input  mem_arb_pkg::addr_t        alloc_addr,
    input  logic                      alloc_for_data,

    // Busy check for the offered address
    input  mem_arb_pkg::addr_t        query_addr,
    output logic                      full,
    output logic                      addr_busy,

    // Entry view for the assembler lookup
    output mem_arb_pkg::table_entry_t entries [mem_arb_pkg::TABLE_DEPTH],

    // Release from the assembler
    input  logic                      free,
    input  mem_arb_pkg::table_idx_t   free_index
);

    import mem_arb_pkg::*;

    logic [TABLE_DEPTH-1:0] valid_q;
    logic [TABLE_DEPTH-1:0] for_data_q;
    addr_t                  addr_q [TABLE_DEPTH];

    logic       slot_found;
    table_idx_t slot_idx;

    always_comb begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            entries[i].valid    = valid_q[i];
            entries[i].for_data = for_data_q[i];
            entries[i].addr     = addr_q[i];
        end
    end

    // Lowest free entry
    always_comb begin
        slot_found = 1'b0;
        slot_idx   = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (!valid_q[i] && !slot_found) begin
                slot_found = 1'b1;
                slot_idx   = table_idx_t'(i);
            end
        end
    end

    assign full = !slot_found;

    // Lines match on their address above the byte offset
    always_comb begin
        addr_busy = 1'b0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (valid_q[i] && addr_q[i][ADDR_W-1:LINE_OFFSET_W]
                              == query_addr[ADDR_W-1:LINE_OFFSET_W]) begin
                addr_busy = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            // Free and alloc never name the same entry
            if (free) begin
                valid_q[free_index] <= 1'b0;
            end
            if (alloc && slot_found) begin
                valid_q[slot_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && slot_found) begin
            for_data_q[slot_idx] <= alloc_for_data;
            addr_q[slot_idx]     <= alloc_addr;
        end
    end

endmodule

//--- mem_arb.f
common/mem_arb_pkg.sv
hw/line_req_arbiter.sv
hw/outstanding_table.sv
hw/burst_assembler.sv
hw/mem_arb_top.sv
test/bmem_model.sv
test/mem_arb_properties.sv
test/mem_arb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert --top-module mem_arb_tb -f mem_arb.f -o mem_arb_sim \
    && ./obj_dir/mem_arb_sim > sim.log 2>&1 \
    && ! grep -q "Test failures found" sim.log \
    && cat sim.log \
    && echo "Simulation passed" \
    && exit 0 \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }

//--- test/bmem_model.sv
`timescale 1ns/10ps

module bmem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             max_delay,
    input  mem_arb_pkg::bmem_cmd_t bmem_cmd,
    output logic                   bmem_ready,
    output mem_arb_pkg::bmem_ret_t bmem_ret,
    output logic                   bmem_rvalid
);

    import mem_arb_pkg::*;

    // Written beats by beat address, unwritten ones read as a fill pattern
    beat_t mem [addr_t];
    time   wr_done_time;

    // Reads in flight with their data and remaining delay
    addr_t       rd_addr [$];
    line_t       rd_line [$];
    int unsigned rd_wait [$];

    function automatic beat_t read_beat(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a ^ 32'h5a5a_c3c3, ~a};
    endfunction

    initial begin
        int    wr_beat;
        int    ret_beat;
        int    ret_sel;
        int    ready_idx [$];
        line_t line;

        wr_beat      = 0;
        ret_beat     = 0;
        ret_sel      = -1;
        wr_done_time = 0;
        bmem_ready   = 1'b0;
        bmem_rvalid  = 1'b0;
        bmem_ret     = '0;
        forever begin
            // Commands are taken on the rising edge
            @(posedge clk);
            if (!rst && bmem_ready && bmem_cmd.write) begin
                mem[bmem_cmd.addr + addr_t'(wr_beat * 8)] = bmem_cmd.wdata;
                wr_beat++;
                if (wr_beat == BEATS_PER_LINE) begin
                    wr_beat      = 0;
                    wr_done_time = $time;
                end
            end else if (!rst && bmem_ready && bmem_cmd.read) begin
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    line[b*BEAT_W +: BEAT_W] = read_beat(bmem_cmd.addr + addr_t'(b * 8));
                end
                rd_addr.push_back(bmem_cmd.addr);
                rd_line.push_back(line);
                rd_wait.push_back($urandom_range(32'(max_delay)));
            end

            @(negedge clk);
            bmem_ready = !rst && ($urandom_range(3) != 0);
            foreach (rd_wait[i]) begin
                if (rd_wait[i] != 0) begin
                    rd_wait[i] = rd_wait[i] - 1;
                end
            end
            // Any read whose delay ran out may go next
            if (ret_sel < 0) begin
                ready_idx.delete();
                foreach (rd_wait[i]) begin
                    if (rd_wait[i] == 0) begin
                        ready_idx.push_back(i);
                    end
                end
                if (ready_idx.size() != 0) begin
                    ret_sel = ready_idx[$urandom_range(ready_idx.size() - 1)];
                end
            end
            bmem_rvalid = (ret_sel >= 0);
            if (ret_sel >= 0) begin
                bmem_ret.raddr = rd_addr[ret_sel];
                bmem_ret.rdata = rd_line[ret_sel][ret_beat*BEAT_W +: BEAT_W];
                ret_beat++;
                if (ret_beat == BEATS_PER_LINE) begin
                    rd_addr.delete(ret_sel);
                    rd_line.delete(ret_sel);
                    rd_wait.delete(ret_sel);
                    ret_beat = 0;
                    ret_sel  = -1;
                end
            end
        end
    end

endmodule

//--- test/mem_arb_properties.sv
`timescale 1ns/10ps

module mem_arb_properties (
    input logic                   clk,
    input logic                   rst,
    input mem_arb_pkg::line_req_t imem_req,
    input logic                   imem_valid,
    input logic                   imem_ready,
    input mem_arb_pkg::line_req_t dmem_req,
    input logic                   dmem_valid,
    input logic                   dmem_ready,
    input mem_arb_pkg::bmem_cmd_t bmem_cmd,
    input logic                   imem_resp_valid,
    input logic                   dmem_resp_valid
);

    int unsigned fail_count = 0;

    // Requests hold still until taken
    imem_hold: assert property (@(posedge clk) disable iff (rst)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_req))
        else begin
            fail_count++;
            $error("imem request changed before it was accepted");
        end

    dmem_hold: assert property (@(posedge clk) disable iff (rst)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_req))
        else begin
            fail_count++;
            $error("dmem request changed before it was accepted");
        end

    cmd_onehot: assert property (@(posedge clk) disable iff (rst)
        !(bmem_cmd.read && bmem_cmd.write))
        else begin
            fail_count++;
            $error("memory read and write high together");
        end

    // Response valids are single pulses
    imem_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_resp_valid |=> !imem_resp_valid)
        else begin
            fail_count++;
            $error("imem response valid longer than one cycle");
        end

    dmem_pulse: assert property (@(posedge clk) disable iff (rst)
        dmem_resp_valid |=> !dmem_resp_valid)
        else begin
            fail_count++;
            $error("dmem response valid longer than one cycle");
        end

endmodule

bind mem_arb_top mem_arb_properties u_props (.*);

//--- test/mem_arb_tb.sv
`timescale 1ns/10ps

module mem_arb_tb;

    import mem_arb_pkg::*;

    localparam int    CLK_PERIOD   = 10;
    localparam int    RESET_CYCLES = 8;
    localparam int    N_SINGLE     = 8;
    localparam int    N_MIXED      = 10;
    localparam int    TOTAL_REQS   = 3 * N_SINGLE + 4 * N_MIXED;
    // Long latency, memory stalls and one competing request, with margin
    localparam int    WORST_CYCLES = 300;
    localparam addr_t IMEM_BASE    = 32'h0001_0000;
    localparam addr_t DMEM_BASE    = 32'h0008_0000;

    logic       clk = 1'b0;
    logic       rst;
    line_req_t  imem_req;
    logic       imem_valid;
    logic       imem_ready;
    line_resp_t imem_resp;
    logic       imem_resp_valid;
    line_req_t  dmem_req;
    logic       dmem_valid;
    logic       dmem_ready;
    line_resp_t dmem_resp;
    logic       dmem_resp_valid;
    bmem_cmd_t  bmem_cmd;
    logic       bmem_ready;
    bmem_ret_t  bmem_ret;
    logic       bmem_rvalid;
    logic [7:0] max_delay;

    // Last line written per address, and the answers each cache still waits for
    line_t ref_store [addr_t];
    line_t imem_exp [$];
    line_t dmem_exp [$];
    logic  dmem_exp_wr [$];

    mem_arb_top DUT (.*);
    bmem_model  mem_model (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Written data if any, else the fill pattern of each beat address
    function automatic line_t expected_line(addr_t addr);
        line_t line;
        addr_t beat_addr;
        if (ref_store.exists(addr)) begin
            return ref_store[addr];
        end
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            beat_addr = addr + addr_t'(b * 8);
            line[b*BEAT_W +: BEAT_W] = {beat_addr ^ 32'h5a5a_c3c3, ~beat_addr};
        end
        return line;
    endfunction

    function automatic line_t random_line();
        line_t line;
        for (int w = 0; w < LINE_W / 32; w++) begin
            line[w*32 +: 32] = $urandom();
        end
        return line;
    endfunction

    // Separate regions, so the two caches never touch one line
    function automatic addr_t imem_addr();
        return IMEM_BASE + addr_t'($urandom_range(255) << 5);
    endfunction

    function automatic addr_t dmem_addr();
        return DMEM_BASE + addr_t'($urandom_range(15) << 5);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic imem_read(input addr_t addr);
        @(negedge clk);
        imem_req.addr  = addr;
        imem_req.write = 1'b0;
        imem_req.wdata = '0;
        imem_valid     = 1'b1;
        @(posedge clk);
        while (!imem_ready) @(posedge clk);
        imem_exp.push_back(expected_line(addr));
        @(negedge clk);
        imem_valid = 1'b0;
        while (imem_exp.size() != 0) @(negedge clk);
    endtask

    task automatic dmem_access(input addr_t addr, input logic write, input line_t wdata);
        @(negedge clk);
        dmem_req.addr  = addr;
        dmem_req.write = write;
        dmem_req.wdata = wdata;
        dmem_valid     = 1'b1;
        @(posedge clk);
        while (!dmem_ready) @(posedge clk);
        if (write) begin
            ref_store[addr] = wdata;
        end
        dmem_exp.push_back(expected_line(addr));
        dmem_exp_wr.push_back(write);
        @(negedge clk);
        dmem_valid = 1'b0;
        while (dmem_exp.size() != 0) @(negedge clk);
    endtask

    // Compare every response against what was expected at grant time
    always @(posedge clk) begin
        line_t exp_line;
        if (!rst) begin
            if (DUT.u_props.fail_count != 0) begin
                abort_run("A handshake assertion failed during the run");
            end
            if (imem_valid && dmem_valid) begin
                check_value("imem_ready with both sides valid", 256'(imem_ready), '0);
            end
            if (imem_resp_valid) begin
                if (imem_exp.size() == 0) begin
                    abort_run("An imem response arrived with no request pending");
                end else begin
                    check_value("imem line", imem_resp.rdata, imem_exp.pop_front());
                end
            end
            if (dmem_resp_valid) begin
                if (dmem_exp.size() == 0) begin
                    abort_run("A dmem response arrived with no request pending");
                end else begin
                    exp_line = dmem_exp.pop_front();
                    if (dmem_exp_wr.pop_front()) begin
                        check_value("write response delay",
                                    256'($time - mem_model.wr_done_time), 256'(CLK_PERIOD));
                    end else begin
                        check_value("dmem line", dmem_resp.rdata, exp_line);
                    end
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TOTAL_REQS * WORST_CYCLES));
        abort_run("The run timed out before all requests were answered");
    end

    initial begin
        addr_t addr;

        void'($urandom(32'hcae4_93c4));
        rst        = 1'b1;
        imem_req   = '0;
        imem_valid = 1'b0;
        dmem_req   = '0;
        dmem_valid = 1'b0;
        max_delay  = 8'd6;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (N_SINGLE) imem_read(imem_addr());

        // Write-back, then read the same line
        repeat (N_SINGLE) begin
            addr = dmem_addr();
            dmem_access(addr, 1'b1, random_line());
            dmem_access(addr, 1'b0, '0);
        end

        fork
            repeat (N_MIXED) imem_read(imem_addr());
            repeat (N_MIXED) dmem_access(dmem_addr(), $urandom_range(1) == 1, random_line());
        join

        // Long latency so reads of both caches overlap and return out of order
        @(negedge clk);
        max_delay = 8'd40;
        fork
            repeat (N_MIXED) imem_read(imem_addr());
            repeat (N_MIXED) dmem_access(dmem_addr(), 1'b0, '0);
        join

        foreach (ref_store[a]) begin
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                check_value("stored beat", 256'(mem_model.mem[a + addr_t'(b * 8)]),
                            256'(ref_store[a][b*BEAT_W +: BEAT_W]));
            end
        end
        check_value("written beat count", 256'(mem_model.mem.num()),
                    256'(ref_store.num() * BEATS_PER_LINE));

        if (DUT.u_props.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("Handshake assertions failed during the run");
        end
    end

endmodule
